//--- Makefile
# Verilator simulation of the reservation station testbench

LOG = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module rsTb -Mdir obj_dir -o Vsim -f tb.f
	./obj_dir/Vsim +verilator+error+limit+100 | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/dispatchUnit.sv
`timescale 1ns/1ps

module dispatchUnit (
    input  logic                                       dispatchValid,
    input  rsPkg::rsControl_t                          dispatchCtrl,
    input  logic [rsPkg::TagW-1:0]                     src1Tag,
    input  logic [rsPkg::TagW-1:0]                     src2Tag,
    input  logic                                       src1Ready,
    input  logic                                       src2Ready,
    input  logic [rsPkg::DataW-1:0]                    src1Data,
    input  logic [rsPkg::DataW-1:0]                    src2Data,
    input  rsPkg::resultBus_t [rsPkg::NumBroadcasts-1:0] broadcasts,
    input  logic [rsPkg::NumEntries-1:0]               busy,
    output logic                                       writeEn,
    output logic [rsPkg::EntryIdxW-1:0]                writeIdx,
    output rsPkg::rsEntry_t                            writeEntry,
    output logic                                       full
);
    import rsPkg::*;

    // register file value first, then a same-cycle broadcast
    function automatic srcOperand_t resolveOperand(
        input logic [TagW-1:0]                 tag,
        input logic                            rdy,
        input logic [DataW-1:0]                rfData,
        input resultBus_t [NumBroadcasts-1:0] buses
    );
        srcOperand_t op;
        resultBus_t  snoop;
        snoop    = snoopBroadcasts(tag, buses);
        op.tag   = tag;
        op.valid = rdy | snoop.valid;
        op.data  = rdy ? rfData : snoop.data;
        return op;
    endfunction

    always_comb begin
        writeIdx = '0;
        for (int i = NumEntries - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                writeIdx = EntryIdxW'(i); // lowest free wins
            end
        end
    end

    assign full    = &busy;
    assign writeEn = dispatchValid & ~full; // dropped when full

    always_comb begin
        writeEntry      = '0;
        writeEntry.busy = 1'b1;
        writeEntry.ctrl = dispatchCtrl;
        writeEntry.op1  = resolveOperand(src1Tag, src1Ready, src1Data, broadcasts);
        writeEntry.op2  = resolveOperand(src2Tag, src2Ready, src2Data, broadcasts);
    end

endmodule

//--- rtl/issueArbiter.sv
`timescale 1ns/1ps

module issueArbiter (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [rsPkg::NumEntries-1:0]            ready,
    input  rsPkg::rsEntry_t [rsPkg::NumEntries-1:0] entries,
    output logic [rsPkg::NumEntries-1:0]            grant,
    output logic                                    issueValid,
    output rsPkg::issueOp_t                         issueOp
);
    import rsPkg::*;

    rsEntry_t winner;
    logic     anyGrant;

    // isolate lowest set bit
    assign grant    = ready & (~ready + NumEntries'(1));
    assign anyGrant = |grant;

    // one-hot mux of the granted entry
    always_comb begin
        winner = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (grant[i]) begin
                winner = entries[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= anyGrant; // one cycle per grant
        end
    end

    always_ff @(posedge clk) begin
        if (anyGrant) begin
            issueOp.ctrl    <= winner.ctrl;
            issueOp.op1Data <= winner.op1.data;
            issueOp.op2Data <= winner.op2.data;
        end
    end

endmodule

//--- rtl/reservationStation.sv
`timescale 1ns/1ps

module reservationStation (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         dispatchValid,
    input  rsPkg::rsControl_t                            dispatchCtrl,
    input  logic [rsPkg::TagW-1:0]                       src1Tag,
    input  logic [rsPkg::TagW-1:0]                       src2Tag,
    input  logic                                         src1Ready,
    input  logic                                         src2Ready,
    input  logic [rsPkg::DataW-1:0]                      src1Data,
    input  logic [rsPkg::DataW-1:0]                      src2Data,
    input  rsPkg::resultBus_t [rsPkg::NumBroadcasts-1:0] broadcasts,
    output logic                                         issueValid,
    output rsPkg::issueOp_t                              issueOp,
    output logic                                         full
);
    import rsPkg::*;

    logic                              writeEn;
    logic [EntryIdxW-1:0]              writeIdx;
    rsEntry_t                          writeEntry;
    logic [NumEntries-1:0]             busy;
    logic [NumEntries-1:0]             ready;
    logic [NumEntries-1:0]             grant;
    rsEntry_t [NumEntries-1:0]         entries;

    dispatchUnit dispatch (
        .dispatchValid (dispatchValid),
        .dispatchCtrl  (dispatchCtrl),
        .src1Tag       (src1Tag),
        .src2Tag       (src2Tag),
        .src1Ready     (src1Ready),
        .src2Ready     (src2Ready),
        .src1Data      (src1Data),
        .src2Data      (src2Data),
        .broadcasts    (broadcasts),
        .busy          (busy),
        .writeEn       (writeEn),
        .writeIdx      (writeIdx),
        .writeEntry    (writeEntry),
        .full          (full)
    );

    rsEntryBank bank (
        .clk        (clk),
        .reset      (reset),
        .writeEn    (writeEn),
        .writeIdx   (writeIdx),
        .writeEntry (writeEntry),
        .broadcasts (broadcasts),
        .grant      (grant),
        .busy       (busy),
        .ready      (ready),
        .entries    (entries)
    );

    issueArbiter arbiter (
        .clk        (clk),
        .reset      (reset),
        .ready      (ready),
        .entries    (entries),
        .grant      (grant),
        .issueValid (issueValid),
        .issueOp    (issueOp)
    );

endmodule

//--- rtl/rsEntryBank.sv
`timescale 1ns/1ps

module rsEntryBank (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         writeEn,
    input  logic [rsPkg::EntryIdxW-1:0]                  writeIdx,
    input  rsPkg::rsEntry_t                              writeEntry,
    input  rsPkg::resultBus_t [rsPkg::NumBroadcasts-1:0] broadcasts,
    input  logic [rsPkg::NumEntries-1:0]                 grant,
    output logic [rsPkg::NumEntries-1:0]                 busy,
    output logic [rsPkg::NumEntries-1:0]                 ready,
    output rsPkg::rsEntry_t [rsPkg::NumEntries-1:0]      entries
);
    import rsPkg::*;

    // per-entry state
    logic [NumEntries-1:0] busyQ;
    logic [NumEntries-1:0] op1ValidQ;
    logic [NumEntries-1:0] op2ValidQ;

    // payload
    rsControl_t       ctrlQ    [NumEntries];
    logic [TagW-1:0]  op1TagQ  [NumEntries];
    logic [TagW-1:0]  op2TagQ  [NumEntries];
    logic [DataW-1:0] op1DataQ [NumEntries];
    logic [DataW-1:0] op2DataQ [NumEntries];

    resultBus_t            snoop1 [NumEntries];
    resultBus_t            snoop2 [NumEntries];
    logic [NumEntries-1:0] wake1;
    logic [NumEntries-1:0] wake2;
    logic [NumEntries-1:0] writeSel;

    assign writeSel = writeEn ? (NumEntries'(1) << writeIdx) : '0;
    assign busy     = busyQ;

    always_comb begin
        for (int i = 0; i < NumEntries; i++) begin
            snoop1[i] = snoopBroadcasts(op1TagQ[i], broadcasts);
            snoop2[i] = snoopBroadcasts(op2TagQ[i], broadcasts);
            wake1[i]  = busyQ[i] & ~op1ValidQ[i] & snoop1[i].valid;
            wake2[i]  = busyQ[i] & ~op2ValidQ[i] & snoop2[i].valid;
            ready[i]  = busyQ[i] & op1ValidQ[i] & op2ValidQ[i];
        end
    end

    always_comb begin
        for (int i = 0; i < NumEntries; i++) begin
            entries[i].busy = busyQ[i];
            entries[i].ctrl = ctrlQ[i];
            entries[i].op1  = '{tag: op1TagQ[i], valid: op1ValidQ[i], data: op1DataQ[i]};
            entries[i].op2  = '{tag: op2TagQ[i], valid: op2ValidQ[i], data: op2DataQ[i]};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busyQ     <= '0;
            op1ValidQ <= '0;
            op2ValidQ <= '0;
        end else begin
            for (int i = 0; i < NumEntries; i++) begin
                if (writeSel[i]) begin
                    busyQ[i]     <= writeEntry.busy;
                    op1ValidQ[i] <= writeEntry.op1.valid;
                    op2ValidQ[i] <= writeEntry.op2.valid;
                end else begin
                    if (grant[i]) begin
                        busyQ[i] <= 1'b0; // freed as the op is registered
                    end
                    if (wake1[i]) begin
                        op1ValidQ[i] <= 1'b1;
                    end
                    if (wake2[i]) begin
                        op2ValidQ[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NumEntries; i++) begin
            if (writeSel[i]) begin
                ctrlQ[i]    <= writeEntry.ctrl;
                op1TagQ[i]  <= writeEntry.op1.tag;
                op2TagQ[i]  <= writeEntry.op2.tag;
                op1DataQ[i] <= writeEntry.op1.data;
                op2DataQ[i] <= writeEntry.op2.data;
            end else begin
                if (wake1[i]) begin
                    op1DataQ[i] <= snoop1[i].data;
                end
                if (wake2[i]) begin
                    op2DataQ[i] <= snoop2[i].data;
                end
            end
        end
    end

endmodule

//--- rtl/rsPkg.sv
package rsPkg;

    localparam int NumEntries    = 16;
    localparam int EntryIdxW     = 4;
    localparam int TagW          = 8;
    localparam int DataW         = 32;
    localparam int NumBroadcasts = 4;

    // result bus indices
    localparam int BusAlu  = 0;
    localparam int BusMul  = 1;
    localparam int BusDiv  = 2;
    localparam int BusLoad = 3;

    // snoop order, first match wins
    localparam int SnoopOrder [NumBroadcasts] = '{BusAlu, BusMul, BusDiv, BusLoad};

    typedef struct packed {
        logic             valid;
        logic [TagW-1:0]  tag;
        logic [DataW-1:0] data;
    } resultBus_t;

    typedef struct packed {
        logic [31:0]     pc;
        logic [TagW-1:0] rd;
        logic [3:0]      aluOp;
        logic [2:0]      funct3;
        logic [31:0]     immediate;
        logic            memToReg;
        logic            memRead;  // also marks a load op
        logic            memWrite;
        logic            aluSrc1;
        logic            aluSrc2;
        logic            jump;
        logic            branch;
    } rsControl_t;

    typedef struct packed {
        logic [TagW-1:0]  tag;
        logic             valid;
        logic [DataW-1:0] data;
    } srcOperand_t;

    typedef struct packed {
        logic        busy;
        rsControl_t  ctrl;
        srcOperand_t op1;
        srcOperand_t op2;
    } rsEntry_t;

    typedef struct packed {
        rsControl_t       ctrl;
        logic [DataW-1:0] op1Data;
        logic [DataW-1:0] op2Data;
    } issueOp_t;

    // valid field of the result carries the hit flag
    function automatic resultBus_t snoopBroadcasts(
        input logic [TagW-1:0]                 tag,
        input resultBus_t [NumBroadcasts-1:0] buses
    );
        resultBus_t match;
        match     = '0;
        match.tag = tag;
        for (int i = 0; i < NumBroadcasts; i++) begin
            if (!match.valid && buses[SnoopOrder[i]].valid &&
                buses[SnoopOrder[i]].tag == tag) begin
                match.valid = 1'b1;
                match.data  = buses[SnoopOrder[i]].data;
            end
        end
        return match;
    endfunction

endpackage

//--- tb.f
rtl/rsPkg.sv
rtl/dispatchUnit.sv
rtl/rsEntryBank.sv
rtl/issueArbiter.sv
rtl/reservationStation.sv
verification/rsTb_asserts.sv
verification/rsTb.sv

//--- verification/rsTb.sv
`timescale 1ns/1ps

module rsTb;
    import rsPkg::*;

    localparam int TimeoutCycles = 20;

    typedef struct packed {
        logic [3:0]       testId;
        logic             dispatch;
        rsControl_t       ctrl;
        logic [TagW-1:0]  src1Tag;
        logic [TagW-1:0]  src2Tag;
        logic             src1Ready;
        logic             src2Ready;
        logic [DataW-1:0] src1Data;
        logic [DataW-1:0] src2Data;
        logic             bcValid;
        logic [1:0]       bcBus;
        logic [TagW-1:0]  bcTag;
        logic [DataW-1:0] bcData;
        logic             expValid;
        logic [3:0]       expLatency; // cycles from the row's edge to issueValid
        logic [TagW-1:0]  expRd;
        logic [DataW-1:0] expOp1;
        logic [DataW-1:0] expOp2;
        logic             expFull;
    } stimRow_t;

    logic                             clk;
    logic                             reset;
    logic                             dispatchValid;
    rsControl_t                       dispatchCtrl;
    logic [TagW-1:0]                  src1Tag;
    logic [TagW-1:0]                  src2Tag;
    logic                             src1Ready;
    logic                             src2Ready;
    logic [DataW-1:0]                 src1Data;
    logic [DataW-1:0]                 src2Data;
    resultBus_t [NumBroadcasts-1:0]   broadcasts;
    logic                             issueValid;
    issueOp_t                         issueOp;
    logic                             full;

    stimRow_t   rows [$];
    rsControl_t ctrlByRd [256]; // last dispatched bundle per rd
    integer     seed;
    int         errors;
    int         testErrors;
    int         testsRun;
    int         testsFailed;
    int         curTest;
    int         assertFails;
    bit         timedOut;

    reservationStation dut (
        .clk           (clk),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .dispatchCtrl  (dispatchCtrl),
        .src1Tag       (src1Tag),
        .src2Tag       (src2Tag),
        .src1Ready     (src1Ready),
        .src2Ready     (src2Ready),
        .src1Data      (src1Data),
        .src2Data      (src2Data),
        .broadcasts    (broadcasts),
        .issueValid    (issueValid),
        .issueOp       (issueOp),
        .full          (full)
    );

    bind reservationStation rsTb_asserts checks (
        .clk        (clk),
        .reset      (reset),
        .issueValid (issueValid),
        .full       (full),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic rsControl_t makeCtrl(input logic [TagW-1:0] rd);
        rsControl_t c;
        c           = '0;
        c.pc        = 32'h0000_1000 + {22'd0, rd, 2'b00};
        c.rd        = rd;
        c.aluOp     = rd[3:0];
        c.funct3    = rd[6:4];
        c.immediate = $random(seed);
        c.memRead   = rd[0];
        c.aluSrc2   = rd[1];
        c.branch    = rd[2];
        return c;
    endfunction

    function automatic stimRow_t idleRow(input logic [3:0] id);
        stimRow_t r;
        r        = '0;
        r.testId = id;
        return r;
    endfunction

    function automatic stimRow_t dispatchRow(
        input logic [3:0]       id,
        input logic [TagW-1:0]  rd,
        input logic [TagW-1:0]  tag1,
        input logic             rdy1,
        input logic [DataW-1:0] data1,
        input logic [TagW-1:0]  tag2,
        input logic             rdy2,
        input logic [DataW-1:0] data2
    );
        stimRow_t r;
        r           = idleRow(id);
        r.dispatch  = 1'b1;
        r.ctrl      = makeCtrl(rd);
        r.src1Tag   = tag1;
        r.src1Ready = rdy1;
        r.src1Data  = data1;
        r.src2Tag   = tag2;
        r.src2Ready = rdy2;
        r.src2Data  = data2;
        return r;
    endfunction

    function automatic stimRow_t withBroadcast(
        input stimRow_t         r,
        input logic [1:0]       bus,
        input logic [TagW-1:0]  tag,
        input logic [DataW-1:0] data
    );
        stimRow_t o;
        o         = r;
        o.bcValid = 1'b1;
        o.bcBus   = bus;
        o.bcTag   = tag;
        o.bcData  = data;
        return o;
    endfunction

    function automatic stimRow_t expectIssue(
        input stimRow_t         r,
        input logic [3:0]       latency,
        input logic [TagW-1:0]  rd,
        input logic [DataW-1:0] op1,
        input logic [DataW-1:0] op2
    );
        stimRow_t o;
        o            = r;
        o.expValid   = 1'b1;
        o.expLatency = latency;
        o.expRd      = rd;
        o.expOp1     = op1;
        o.expOp2     = op2;
        return o;
    endfunction

    function automatic string testName(input int id);
        case (id)
            1: return "quiet after reset";
            2: return "ready dispatch";
            3: return "multiplier wakeup";
            4: return "load bypass at dispatch";
            5: return "double wakeup order";
            6: return "fill, drop and drain";
            default: return "unknown";
        endcase
    endfunction

    task automatic buildTable();
        stimRow_t row;
        repeat (5) rows.push_back(idleRow(4'd1));
        row = dispatchRow(4'd2, 8'h21, 8'h01, 1'b1, 32'h1111_0001, 8'h02, 1'b1, 32'h2222_0002);
        rows.push_back(expectIssue(row, 4'd1, 8'h21, 32'h1111_0001, 32'h2222_0002));
        // rf data of a waiting operand is junk
        rows.push_back(dispatchRow(4'd3, 8'h31, 8'h03, 1'b1, 32'h3333_0001,
                                   8'h11, 1'b0, 32'hdead_0000));
        repeat (3) rows.push_back(idleRow(4'd3));
        row = withBroadcast(idleRow(4'd3), 2'(BusMul), 8'h11, 32'hcafe_0003);
        rows.push_back(expectIssue(row, 4'd1, 8'h31, 32'h3333_0001, 32'hcafe_0003));
        row = dispatchRow(4'd4, 8'h41, 8'h05, 1'b1, 32'h4444_0001, 8'h22, 1'b0, 32'hdead_0000);
        row = withBroadcast(row, 2'(BusLoad), 8'h22, 32'h10ad_0004);
        rows.push_back(expectIssue(row, 4'd1, 8'h41, 32'h4444_0001, 32'h10ad_0004));
        rows.push_back(dispatchRow(4'd5, 8'h50, 8'h33, 1'b0, 32'hdead_0000,
                                   8'h06, 1'b1, 32'h5555_0002));
        rows.push_back(dispatchRow(4'd5, 8'h51, 8'h07, 1'b1, 32'h5555_0011,
                                   8'h33, 1'b0, 32'hdead_0000));
        row = withBroadcast(idleRow(4'd5), 2'(BusAlu), 8'h33, 32'ha100_0005);
        rows.push_back(expectIssue(row, 4'd1, 8'h50, 32'ha100_0005, 32'h5555_0002));
        rows.push_back(expectIssue(idleRow(4'd5), 4'd0, 8'h51, 32'h5555_0011, 32'ha100_0005));
        for (int i = 0; i < NumEntries; i++) begin
            row = dispatchRow(4'd6, 8'h60 + 8'(i), 8'h80 + 8'(i), 1'b1, 32'h6000_0000 + 32'(i),
                              8'h44, 1'b0, 32'hdead_0000);
            row.expFull = (i == NumEntries - 1);
            rows.push_back(row);
        end
        // both ready, so a wrong write would show up as an issue
        row = dispatchRow(4'd6, 8'h7f, 8'h08, 1'b1, 32'h7777_0001, 8'h09, 1'b1, 32'h7777_0002);
        row.expFull = 1'b1;
        rows.push_back(row);
        row = withBroadcast(idleRow(4'd6), 2'(BusDiv), 8'h44, 32'hd1d0_0006);
        rows.push_back(expectIssue(row, 4'd1, 8'h60, 32'h6000_0000, 32'hd1d0_0006));
        for (int i = 1; i < NumEntries; i++) begin
            rows.push_back(expectIssue(idleRow(4'd6), 4'd0, 8'h60 + 8'(i),
                                       32'h6000_0000 + 32'(i), 32'hd1d0_0006));
        end
        repeat (3) rows.push_back(idleRow(4'd6));
    endtask

    task automatic reportError(input string msg);
        $display("ERROR @ %0d ns: %s", $time, msg);
        errors++;
        testErrors++;
    endtask

    task automatic applyRow(input stimRow_t r);
        dispatchValid = r.dispatch;
        dispatchCtrl  = r.ctrl;
        src1Tag       = r.src1Tag;
        src2Tag       = r.src2Tag;
        src1Ready     = r.src1Ready;
        src2Ready     = r.src2Ready;
        src1Data      = r.src1Data;
        src2Data      = r.src2Data;
        broadcasts    = '0;
        if (r.bcValid) begin
            broadcasts[r.bcBus] = '{valid: 1'b1, tag: r.bcTag, data: r.bcData};
        end
        if (r.dispatch) begin
            ctrlByRd[r.ctrl.rd] = r.ctrl;
        end
        @(posedge clk);
        #1;
        dispatchValid = 1'b0; // strobes last one cycle
        broadcasts    = '0;
    endtask

    task automatic checkRow(input stimRow_t r);
        int cycles;
        cycles = 0;
        if (r.expValid) begin
            while (!issueValid && cycles < TimeoutCycles) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (!issueValid) begin
                $display("timeout: no issue seen within %0d cycles in test %0d",
                         TimeoutCycles, r.testId);
                errors++;
                testErrors++;
                timedOut = 1'b1;
            end else begin
                if (cycles != int'(r.expLatency)) begin
                    reportError($sformatf("issue after %0d cycles, expected %0d",
                                          cycles, r.expLatency));
                end
                if (issueOp.ctrl.rd !== r.expRd) begin
                    reportError($sformatf("issued rd %02h, expected %02h",
                                          issueOp.ctrl.rd, r.expRd));
                end
                if (issueOp.ctrl !== ctrlByRd[r.expRd]) begin
                    reportError($sformatf("control bundle of rd %02h differs, pc %08h imm %08h",
                                          r.expRd, issueOp.ctrl.pc, issueOp.ctrl.immediate));
                end
                if (issueOp.op1Data !== r.expOp1) begin
                    reportError($sformatf("op1Data %08h, expected %08h",
                                          issueOp.op1Data, r.expOp1));
                end
                if (issueOp.op2Data !== r.expOp2) begin
                    reportError($sformatf("op2Data %08h, expected %08h",
                                          issueOp.op2Data, r.expOp2));
                end
            end
        end else begin
            if (issueValid !== 1'b0) begin
                reportError($sformatf("unexpected issue of rd %02h", issueOp.ctrl.rd));
            end
        end
        if (full !== r.expFull) begin
            reportError($sformatf("full is %b, expected %b", full, r.expFull));
        end
    endtask

    task automatic closeTest(input int id);
        testsRun++;
        if (testErrors == 0) begin
            $display("test %0d (%s): passed", id, testName(id));
        end else begin
            testsFailed++;
            $display("test %0d (%s): failed with %0d errors", id, testName(id), testErrors);
        end
        testErrors = 0;
    endtask

    initial begin
        seed          = 32'h1348_fce5;
        reset         = 1'b1;
        dispatchValid = 1'b0;
        dispatchCtrl  = '0;
        src1Tag       = '0;
        src2Tag       = '0;
        src1Ready     = 1'b0;
        src2Ready     = 1'b0;
        src1Data      = '0;
        src2Data      = '0;
        broadcasts    = '0;
        errors        = 0;
        testErrors    = 0;
        testsRun      = 0;
        testsFailed   = 0;
        timedOut      = 1'b0;
        buildTable();
        repeat (10) @(posedge clk);
        #1;
        reset   = 1'b0;
        curTest = 1;
        if (issueValid !== 1'b0) begin
            reportError("issueValid high right after reset");
        end
        if (full !== 1'b0) begin
            reportError("full high right after reset");
        end
        for (int i = 0; i < rows.size() && !timedOut; i++) begin
            if (int'(rows[i].testId) != curTest) begin
                closeTest(curTest);
                curTest = int'(rows[i].testId);
            end
            applyRow(rows[i]);
            checkRow(rows[i]);
        end
        closeTest(curTest);
        assertFails = int'(dut.checks.failCount);
        if (assertFails != 0) begin
            $display("%0d concurrent assertions fired", assertFails);
            errors += assertFails;
        end
        $display("tests run: %0d, tests failed: %0d, errors: %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verification/rsTb_asserts.sv
`timescale 1ns/1ps

module rsTb_asserts (
    input logic                         clk,
    input logic                         reset,
    input logic                         issueValid,
    input logic                         full,
    input logic [rsPkg::NumEntries-1:0] busy
);
    int unsigned failCount; // read by the testbench at the end

    initial begin
        failCount = 0;
    end

    resetQuiet: assert property (@(posedge clk) reset && $past(reset) |-> !issueValid)
        else begin
            failCount++;
            $error("issueValid high while in reset");
        end

    knownOutputs: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({full, issueValid}))
        else begin
            failCount++;
            $error("full or issueValid unknown");
        end

    // each issue frees exactly one entry on its edge
    issueFreesOne: assert property (@(posedge clk) disable iff (reset)
        issueValid |-> $onehot($past(busy) & ~busy))
        else begin
            failCount++;
            $error("issue without exactly one entry freed");
        end

    singleFree: assert property (@(posedge clk) disable iff (reset)
        $onehot0($past(busy) & ~busy))
        else begin
            failCount++;
            $error("more than one entry freed on one edge");
        end

endmodule
